/* project.f */
hdl/bank_mem_pkg.sv
hdl/mem_core.sv
hdl/mem_bank.sv
hdl/bank_dispatch.sv
hdl/bank_return.sv
hdl/bank_mem_top.sv
verification/bank_mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the banked scratchpad testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=bank_mem_tb
OBJ_DIR=obj_dir
LOG_FILE=sim.log
FAIL_TEXT="Simulation failed"

echo "Building ${TOP}"
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module "${TOP}" -Mdir "${OBJ_DIR}"
build_status=$?
if [ ${build_status} -ne 0 ]; then
  echo "Verilator build failed with status ${build_status}"
  exit 1
fi

echo "Running ${TOP}"
"./${OBJ_DIR}/V${TOP}" > "${LOG_FILE}" 2>&1
run_status=$?
cat "${LOG_FILE}"
if [ ${run_status} -ne 0 ]; then
  echo "Simulator exited with status ${run_status}"
  exit 1
fi

if grep -q "${FAIL_TEXT}" "${LOG_FILE}"; then
  echo "Result: FAIL, see ${LOG_FILE}"
  exit 1
fi

echo "Result: PASS"
exit 0

/* verification/bank_mem_tb.sv */
// Testbench for the banked scratchpad, drives the req/ack port of bank_mem_top
// Runs a fill sweep, a stimulus table, handshake timing and a random mix against a model

`timescale 1ns/1ps

module bank_mem_tb import bank_mem_pkg::*; ();

  localparam int          WAIT_LIMIT   = 20;            // Negedges before a wait gives up
  localparam int          ACK_EDGES    = 2;             // Ack after the edge that samples req
  localparam int          REL_NEGEDGES = 2;             // Negedges from req drop to ack low
  localparam int          TABLE_LEN    = 16;
  localparam int          RANDOM_OPS   = 200;
  localparam logic [31:0] SEED         = 32'h23af_3d59;

  // One row of the stimulus table
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] exp_data;  // Expected read value, unused on writes
  } table_entry_t;

  logic              clk_i;
  logic              reset_i;
  logic              req_i;
  mem_req_t          req_data_i;
  logic              ack_o;
  logic [DATA_W-1:0] rdata_o;

  logic [DATA_W-1:0] model [256];     // Mirror of the whole memory
  table_entry_t      tbl [TABLE_LEN];
  int                check_count = 0;
  int                error_count = 0;
  logic              timeout_hit = 1'b0;

  bank_mem_top u_dut (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .ack_o      (ack_o),
    .rdata_o    (rdata_o)
  );

  always #50 clk_i = ~clk_i;  // 100 ns period

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // Byte-enable rule, new byte where be is set
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] result;
    result = old_word;
    for (int i = 0; i < BE_W; i++) begin
      if (be[i]) result[8*i +: 8] = new_word[8*i +: 8];
    end
    return result;
  endfunction

  // Every address bit shows up in the word
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
    return {addr, ~addr, addr ^ 8'h5A, addr + 8'h3C};
  endfunction

  // One full four-phase handshake with timing checks
  task automatic run_request(input mem_req_t req, input int unsigned hold,
                             output logic [DATA_W-1:0] rdata);
    int                cycles;
    logic [DATA_W-1:0] held_data;
    rdata = '0;
    if (timeout_hit) return;     // Run is already lost
    @(posedge clk_i);
    req_i      <= 1'b1;
    req_data_i <= req;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!ack_o && cycles < WAIT_LIMIT);
    if (!ack_o) begin
      $display("Timeout at %0t ns: no ack for address %h", $time, req.addr);
      timeout_hit = 1'b1;
      return;
    end
    // Sampling edge comes one cycle after the drive edge
    check_value("ack_o delay", ACK_EDGES, cycles - 2);
    held_data = rdata_o;
    rdata     = rdata_o;
    repeat (hold) begin          // Requester stalls, ack must hold
      @(negedge clk_i);
      check_value("ack_o", 32'(1'b1), 32'(ack_o));
      check_value("rdata_o", held_data, rdata_o);
    end
    @(posedge clk_i);
    req_i <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (ack_o && cycles < WAIT_LIMIT);
    if (ack_o) begin
      $display("Timeout at %0t ns: ack stayed high after req dropped", $time);
      timeout_hit = 1'b1;
      return;
    end
    check_value("ack_o release", REL_NEGEDGES, cycles);
  endtask

  task automatic apply_op(input logic write, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be,
                          input int unsigned hold, output logic [DATA_W-1:0] rdata);
    mem_req_t req;
    req.write = write;
    req.addr  = addr;
    req.wdata = wdata;
    req.be    = be;
    run_request(req, hold, rdata);
    if (write) model[addr] = merge_bytes(model[addr], wdata, be);  // Track the memory
  endtask

  function automatic table_entry_t make_entry(input logic w, input logic [ADDR_W-1:0] a,
                                              input logic [DATA_W-1:0] d,
                                              input logic [BE_W-1:0] be,
                                              input logic [DATA_W-1:0] e);
    return '{w, a, d, be, e};
  endfunction

  task automatic report_test(input int num, input string name, input int checks_before,
                             input int errors_before);
    $display("Test %0d %s done: %0d checks, %0d errors", num, name,
             check_count - checks_before, error_count - errors_before);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    logic [DATA_W-1:0] rd;
    logic [ADDR_W-1:0] addr;
    logic              write;
    int                c0;
    int                e0;
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    req_i      = 1'b0;
    req_data_i = '0;
    void'($urandom(SEED));
    // Partial merges on one word, hand-derived results
    tbl[0]  = make_entry(1'b1, 8'h15, 32'h1122_3344, 4'b1111, 32'h0);
    tbl[1]  = make_entry(1'b0, 8'h15, 32'h0,         4'b0000, 32'h1122_3344);
    tbl[2]  = make_entry(1'b1, 8'h15, 32'hAAAA_AAAA, 4'b0001, 32'h0);
    tbl[3]  = make_entry(1'b0, 8'h15, 32'h0,         4'b0000, 32'h1122_33AA);
    tbl[4]  = make_entry(1'b1, 8'h15, 32'h5566_7788, 4'b0110, 32'h0);
    tbl[5]  = make_entry(1'b0, 8'h15, 32'h0,         4'b0000, 32'h1166_77AA);
    tbl[6]  = make_entry(1'b1, 8'h15, 32'hCCDD_EEFF, 4'b1000, 32'h0);
    tbl[7]  = make_entry(1'b0, 8'h15, 32'h0,         4'b0000, 32'hCC66_77AA);
    // Word 0x2A in banks 0 to 3
    tbl[8]  = make_entry(1'b1, 8'hA8, 32'hB000_0A2A, 4'b1111, 32'h0);
    tbl[9]  = make_entry(1'b1, 8'hA9, 32'hB111_1A2A, 4'b1111, 32'h0);
    tbl[10] = make_entry(1'b1, 8'hAA, 32'hB222_2A2A, 4'b1111, 32'h0);
    tbl[11] = make_entry(1'b1, 8'hAB, 32'hB333_3A2A, 4'b1111, 32'h0);
    tbl[12] = make_entry(1'b0, 8'hA8, 32'h0,         4'b0000, 32'hB000_0A2A);
    tbl[13] = make_entry(1'b0, 8'hA9, 32'h0,         4'b0000, 32'hB111_1A2A);
    tbl[14] = make_entry(1'b0, 8'hAA, 32'h0,         4'b0000, 32'hB222_2A2A);
    tbl[15] = make_entry(1'b0, 8'hAB, 32'h0,         4'b0000, 32'hB333_3A2A);
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);

    // Fill and read back every address
    c0 = check_count;
    e0 = error_count;
    check_value("ack_o after reset", 32'(1'b0), 32'(ack_o));
    for (int a = 0; a < 256; a++) apply_op(1'b1, ADDR_W'(a), fill_word(ADDR_W'(a)), 4'hF, 0, rd);
    for (int a = 0; a < 256; a++) begin
      apply_op(1'b0, ADDR_W'(a), '0, '0, 0, rd);
      check_value("rdata_o", model[a], rd);
    end
    report_test(1, "fill sweep", c0, e0);

    c0 = check_count;
    e0 = error_count;
    for (int t = 0; t < TABLE_LEN; t++) begin
      apply_op(tbl[t].write, tbl[t].addr, tbl[t].wdata, tbl[t].be, $urandom_range(7, 0), rd);
      if (!tbl[t].write) check_value("rdata_o", tbl[t].exp_data, rd);
      if (t == 7) begin
        report_test(2, "partial writes", c0, e0);
        c0 = check_count;
        e0 = error_count;
      end
    end
    report_test(3, "bank independence", c0, e0);

    c0 = check_count;
    e0 = error_count;
    for (int n = 0; n < 8; n++) begin           // Stretched holds on reads
      addr = ADDR_W'($urandom);
      apply_op(1'b0, addr, '0, '0, $urandom_range(7, 0), rd);
      check_value("rdata_o", model[addr], rd);
    end
    report_test(4, "handshake timing", c0, e0);

    c0 = check_count;
    e0 = error_count;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      write = 1'($urandom);
      addr  = ADDR_W'($urandom);
      apply_op(write, addr, $urandom, BE_W'($urandom), $urandom_range(3, 0), rd);
      if (!write) check_value("rdata_o", model[addr], rd);
    end
    report_test(5, "random mix", c0, e0);

    $display("Checks: %0d, errors: %0d, timeout: %0d", check_count, error_count, timeout_hit);
    if (error_count == 0 && !timeout_hit) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* hdl/bank_mem_top.sv */
// Banked scratchpad top level
// Dispatcher, four bank units and the return block behind one req/ack port

`timescale 1ns/1ps

module bank_mem_top import bank_mem_pkg::*; (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              req_i,       // Four-phase request
  input  mem_req_t          req_data_i,  // Stable while req_i is high
  output logic              ack_o,       // High two cycles after req sampled
  output logic [DATA_W-1:0] rdata_o      // Valid while ack_o after a read
);

  ////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////

  bank_cmd_t cmd [NUM_BANKS];  // Dispatcher to banks
  bank_rsp_t rsp [NUM_BANKS];  // Banks to return block
  logic      idle;             // Return block to dispatcher

  ////////////////////////////////////////
  // Front end
  ////////////////////////////////////////

  bank_dispatch u_dispatch (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .idle_i     (idle),
    .cmd_o      (cmd)
  );

  // One unit per bank select value
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    mem_bank u_bank (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .cmd_i   (cmd[b]),
      .rsp_o   (rsp[b])
    );
  end

  ////////////////////////////////////////
  // Back end
  ////////////////////////////////////////

  bank_return u_return (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (req_i),
    .rsp_i   (rsp),
    .ack_o   (ack_o),
    .rdata_o (rdata_o),
    .idle_o  (idle)
  );

endmodule

/* hdl/bank_return.sv */
// Back end of the handshake
// Takes the single bank response, raises ack and releases it when req falls

`timescale 1ns/1ps

module bank_return import bank_mem_pkg::*; (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              req_i,
  input  bank_rsp_t         rsp_i [NUM_BANKS],  // One response per bank
  output logic              ack_o,
  output logic [DATA_W-1:0] rdata_o,            // Held until the next ack
  output logic              idle_o              // Dispatcher may take a request
);

  logic [NUM_BANKS-1:0] rsp_vld;   // Valid bits gathered
  logic [DATA_W-1:0]    rsp_data;  // Data of the valid bank
  logic                 ack_q;
  logic                 pend_q;    // Request seen, through ack release
  logic [DATA_W-1:0]    rdata_q;
  logic                 release_now;

  ////////////////////////////////////////
  // Response merge
  ////////////////////////////////////////

  // At most one bank answers, so an OR picks it
  always_comb begin
    rsp_data = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      rsp_vld[b] = rsp_i[b].valid;
      rsp_data   = rsp_data | (rsp_i[b].valid ? rsp_i[b].rdata : '0);
    end
  end

  assign release_now = ack_q && !req_i;  // Requester has dropped req

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q  <= 1'b0;
      pend_q <= 1'b0;
    end else begin
      if (req_i && !pend_q) pend_q <= 1'b1;   // Request just taken
      else if (release_now) pend_q <= 1'b0;
      if (|rsp_vld)         ack_q  <= 1'b1;
      else if (release_now) ack_q  <= 1'b0;   // Same edge as idle rising
    end
  end

  // Read data latch
  always_ff @(posedge clk_i) begin
    if (|rsp_vld) rdata_q <= rsp_data;
  end

  assign ack_o   = ack_q;
  assign rdata_o = rdata_q;
  assign idle_o  = !pend_q;

  // Checks
  a_single_rsp : assert property (
    @(posedge clk_i) disable iff (reset_i) $onehot0(rsp_vld)
  );
  a_ack_needs_req : assert property (
    @(posedge clk_i) disable iff (reset_i) $rose(ack_q) |-> req_i
  );

endmodule

/* hdl/bank_dispatch.sv */
// Front end of the four-phase handshake
// Captures a request, decodes the bank and sends it a one-cycle command

`timescale 1ns/1ps

module bank_dispatch import bank_mem_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      req_i,                // Four-phase request
  input  mem_req_t  req_data_i,           // Stable while req_i is high
  input  logic      idle_i,               // Return block has released ack
  output bank_cmd_t cmd_o [NUM_BANKS]     // One command slot per bank
);

  ////////////////////////////////////////
  // State
  ////////////////////////////////////////

  logic                  busy_q;   // Request taken, waiting for release
  logic [NUM_BANKS-1:0]  vld_q;    // Per-bank command valid, one-hot or zero
  mem_req_t              req_q;    // Captured request payload
  logic                  accept;   // Take a new request this edge
  logic [BANK_SEL_W-1:0] sel;      // Bank select of the incoming request

  assign sel = req_data_i.addr[BANK_SEL_W-1:0];  // Low address bits

  // New request only when both sides are idle
  assign accept = req_i && idle_i && !busy_q;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      vld_q  <= '0;
    end else begin
      // Valid lasts one cycle, then drops while busy
      for (int b = 0; b < NUM_BANKS; b++) begin
        vld_q[b] <= accept && (sel == BANK_SEL_W'(b));
      end
      if (accept) begin
        busy_q <= 1'b1;
      end else if (busy_q && idle_i) begin
        busy_q <= 1'b0;  // Ack has come and gone
      end
    end
  end

  // Payload register, loaded on accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_data_i;
    end
  end

  ////////////////////////////////////////
  // Command fan-out
  ////////////////////////////////////////

  // Payload goes to every bank, only the valid bit is decoded
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      cmd_o[b].valid     = vld_q[b];
      cmd_o[b].write     = req_q.write;
      cmd_o[b].word_addr = req_q.addr[ADDR_W-1:BANK_SEL_W];  // Drop bank bits
      cmd_o[b].wdata     = req_q.wdata;
      cmd_o[b].be        = req_q.be;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Return block goes pending on the accept edge
  // Otherwise busy would clear early and a held req would issue a second command
  a_no_cmd_while_busy : assert property (
    @(posedge clk_i) disable iff (reset_i) $rose(busy_q) |-> !idle_i
  );

endmodule

/* hdl/mem_bank.sv */
// One bank unit around mem_core
// Adds byte-enable merge on writes and a registered response port

`timescale 1ns/1ps

module mem_bank import bank_mem_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  bank_cmd_t cmd_i,   // One-cycle command from the dispatcher
  output bank_rsp_t rsp_o    // Answer one edge later
);

  ////////////////////////////////////////
  // Core and merge
  ////////////////////////////////////////

  logic [DATA_W-1:0] old_word;   // Current contents at word_addr
  logic [DATA_W-1:0] new_word;   // Old word with enabled bytes replaced
  logic              core_we;    // Write strobe into the core

  // Only a valid write touches the array
  assign core_we = cmd_i.valid && cmd_i.write;

  mem_core #(
    .ELEM_WIDTH (DATA_W),
    .ADDR_WIDTH (WORD_AW)
  ) u_core (
    .clk_i   (clk_i),
    .we_i    (core_we),
    .addr_i  (cmd_i.word_addr),
    .wdata_i (new_word),
    .rdata_o (old_word)
  );

  // Read-modify-write, byte by byte
  always_comb begin
    for (int i = 0; i < BE_W; i++) begin
      if (cmd_i.be[i]) begin
        new_word[8*i +: 8] = cmd_i.wdata[8*i +: 8];  // Take new byte
      end else begin
        new_word[8*i +: 8] = old_word[8*i +: 8];     // Keep old byte
      end
    end
  end

  ////////////////////////////////////////
  // Response register
  ////////////////////////////////////////

  logic              rsp_vld_q;   // One-cycle valid pulse
  logic [DATA_W-1:0] rsp_data_q;  // Returned word

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_vld_q <= 1'b0;
    end else begin
      rsp_vld_q <= cmd_i.valid;  // Every command answers, reads and writes
    end
  end

  // Data path, loaded only on a command
  always_ff @(posedge clk_i) begin
    if (cmd_i.valid) begin
      rsp_data_q <= cmd_i.write ? new_word : old_word;
    end
  end

  assign rsp_o = '{valid: rsp_vld_q, rdata: rsp_data_q};

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Handshake allows one request at a time, so never back-to-back commands
  a_no_back_to_back : assert property (
    @(posedge clk_i) disable iff (reset_i) cmd_i.valid |=> !cmd_i.valid
  );

endmodule

/* hdl/mem_core.sv */
// Generic single-port memory array
// Read is combinational at the address, write lands on the clock edge

`timescale 1ns/1ps

module mem_core #(
  parameter int ELEM_WIDTH = 8,  // Bits per word
  parameter int ADDR_WIDTH = 8   // Address bits, depth is 2**ADDR_WIDTH
) (
  input  logic                  clk_i,
  input  logic                  we_i,     // Write strobe
  input  logic [ADDR_WIDTH-1:0] addr_i,   // Shared read/write address
  input  logic [ELEM_WIDTH-1:0] wdata_i,
  output logic [ELEM_WIDTH-1:0] rdata_o   // Word at addr_i, no latency
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  localparam int DEPTH = 2 ** ADDR_WIDTH;  // Word count

  // Plain array, no reset on the contents
  logic [ELEM_WIDTH-1:0] mem [DEPTH];

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////

  // Asynchronous read, same cycle as the address
  assign rdata_o = mem[addr_i];

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  // New word visible to the read port after the edge
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[addr_i] <= wdata_i;  // Full-word write
    end
  end

  // Old word is still read during the write cycle,
  // which the bank relies on for its byte merge

endmodule

/* hdl/bank_mem_pkg.sv */
// Shared sizes and bus structs for the banked scratchpad
// Import with bank_mem_pkg::* in the module header

package bank_mem_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  localparam int DATA_W     = 32;           // Data word width
  localparam int BE_W       = DATA_W / 8;   // One enable per byte
  localparam int NUM_BANKS  = 4;            // Bank units

  // Address split, bank select sits in the low bits
  localparam int BANK_SEL_W = 2;                     // Bank select bits
  localparam int WORD_AW    = 6;                     // Word address inside a bank
  localparam int ADDR_W     = BANK_SEL_W + WORD_AW;  // Requester address width

  ////////////////////////////////////////
  // Bus structs
  ////////////////////////////////////////

  // Held stable by the requester while req is high
  typedef struct packed {
    logic              write;  // 1 = write, 0 = read
    logic [ADDR_W-1:0] addr;   // Word address, bank in low bits
    logic [DATA_W-1:0] wdata;  // Write data
    logic [BE_W-1:0]   be;     // Byte enables for writes
  } mem_req_t;

  // One command into a bank, valid for a single cycle
  typedef struct packed {
    logic               valid;
    logic               write;
    logic [WORD_AW-1:0] word_addr;  // Address inside the bank
    logic [DATA_W-1:0]  wdata;
    logic [BE_W-1:0]    be;
  } bank_cmd_t;

  // Bank answer, one edge after the command
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;  // Old word on read, merged word on write
  } bank_rsp_t;

endpackage
